/* div_config.svh */
// Divider unit widths

`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// Operand widths
`define DIV_W_DIVIDEND 44
`define DIV_W_DIVISOR  12

// Quotient bits resolved per pipeline stage
`define DIV_W_DIGIT    4

// Caller tag returned with each result
`define DIV_W_TAG      4

`endif

/* div_pkg.sv */
// Divider unit types

`include "div_config.svh"

package div_pkg;

	localparam int div_w_quotient = `DIV_W_DIVIDEND - `DIV_W_DIVISOR; // 32
	localparam int div_w_partial  = `DIV_W_DIVISOR + `DIV_W_DIGIT;    // Digit divider input
	localparam int div_n_stages   = div_w_quotient / `DIV_W_DIGIT;    // 8

	typedef enum logic [1:0] {
		OK          = 2'd0,
		DIV_BY_ZERO = 2'd1,
		OVERFLOW    = 2'd2
	} div_status_t;

	typedef logic [`DIV_W_DIVIDEND-1:0] dividend_t;
	typedef logic [`DIV_W_DIVISOR-1:0]  divisor_t;
	typedef logic [div_w_quotient-1:0]  quotient_t;
	typedef logic [`DIV_W_DIGIT-1:0]    digit_t;
	typedef logic [`DIV_W_TAG-1:0]      tag_t;

endpackage

/* div_req_if.sv */
// Classified divide request

`timescale 1ns/100ps

interface div_req_if
	import div_pkg::*;
();

	logic        valid;    // One strobe per request
	dividend_t   dividend;
	divisor_t    divisor;
	tag_t        tag;
	div_status_t status;   // Set by the guard, never retested downstream

	modport guard (
		output valid,
		output dividend,
		output divisor,
		output tag,
		output status
	);

	modport pipe (
		input valid,
		input dividend,
		input divisor,
		input tag,
		input status
	);

endinterface

/* div_digit.sv */
// Radix-16 digit divider

`timescale 1ns/100ps

`include "div_config.svh"

module div_digit
	import div_pkg::*;
(
	input  logic [div_w_partial-1:0] partial,
	input  divisor_t                 divisor,
	output digit_t                   digit,
	output divisor_t                 remainder
);

	logic [`DIV_W_DIVISOR:0]   trial;  // Shifted remainder plus next bit
	logic [`DIV_W_DIVISOR:0]   diff;
	logic [`DIV_W_DIVISOR-1:0] rem;

	// Four restoring steps, most significant quotient bit first.
	// Upper bits of partial are assumed below the divisor, so each
	// trial stays under twice the divisor and the result fits.
	always_comb begin
		trial = '0;
		diff  = '0;
		digit = '0;
		rem   = partial[div_w_partial-1 -: `DIV_W_DIVISOR];

		for (int k = `DIV_W_DIGIT-1; k >= 0; k--) begin
			trial = {rem, partial[k]};
			diff  = trial - {1'b0, divisor};
			if (trial >= {1'b0, divisor}) begin
				rem      = diff[`DIV_W_DIVISOR-1:0];  // Subtract succeeds
				digit[k] = 1'b1;
			end else begin
				rem      = trial[`DIV_W_DIVISOR-1:0]; // Restore
				digit[k] = 1'b0;
			end
		end

		remainder = rem;
	end

endmodule

/* div_guard.sv */
// Divider input guard
// Registers requests and classifies them

`timescale 1ns/100ps

`include "div_config.svh"

module div_guard
	import div_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      in_valid,
	input  dividend_t in_dividend,
	input  divisor_t  in_divisor,
	input  tag_t      in_tag,

	div_req_if.guard  req
);

	divisor_t    dividend_top;  // Bits that must stay below the divisor
	div_status_t status_c;

	assign dividend_top = in_dividend[`DIV_W_DIVIDEND-1 -: `DIV_W_DIVISOR];

	// Zero divisor takes priority over overflow
	always_comb begin
		if (in_divisor == '0) begin
			status_c = DIV_BY_ZERO;
		end else if (dividend_top >= in_divisor) begin
			status_c = OVERFLOW;    // Quotient would need more than 32 bits
		end else begin
			status_c = OK;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req.valid    <= 1'b0;
			req.dividend <= '0;
			req.divisor  <= '0;
			req.tag      <= '0;
			req.status   <= OK;
		end else begin
			req.valid    <= in_valid;
			req.dividend <= in_dividend;
			req.divisor  <= in_divisor;
			req.tag      <= in_tag;
			req.status   <= status_c;
		end
	end

endmodule

/* div_pipe.sv */
// Eight-stage divider pipeline
// Four quotient bits per stage, saturation at the output

`timescale 1ns/100ps

`include "div_config.svh"

module div_pipe
	import div_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	div_req_if.pipe     req,

	output logic        out_valid,
	output quotient_t   out_quotient,
	output divisor_t    out_remainder,
	output tag_t        out_tag,
	output div_status_t out_status
);

	localparam int w_shift = div_w_quotient - `DIV_W_DIGIT; // Dividend bits kept per stage

	// Remainder in the top 12 bits, pending dividend bits below,
	// quotient digits collected at the bottom
	dividend_t   rq_r   [1:div_n_stages];
	divisor_t    dvs_r  [1:div_n_stages-1];  // Each request keeps its own divisor
	logic        vld_r  [1:div_n_stages];
	tag_t        tag_r  [1:div_n_stages];
	div_status_t st_r   [1:div_n_stages];

	digit_t      quot   [0:div_n_stages-1];
	divisor_t    remd   [0:div_n_stages-1];

	for (genvar i = 0; i < div_n_stages; i++) begin : g_stage
		logic [div_w_partial-1:0] stage_part;
		divisor_t                 stage_dvs;

		if (i == 0) begin : g_head
			assign stage_part = req.dividend[`DIV_W_DIVIDEND-1 -: div_w_partial];
			assign stage_dvs  = req.divisor;
		end else begin : g_body
			assign stage_part = rq_r[i][`DIV_W_DIVIDEND-1 -: div_w_partial];
			assign stage_dvs  = dvs_r[i];
		end

		div_digit u_digit (
			.partial   (stage_part),
			.divisor   (stage_dvs),
			.digit     (quot[i]),
			.remainder (remd[i])
		);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int j = 1; j <= div_n_stages; j++) begin
				rq_r[j]  <= '0;
				vld_r[j] <= 1'b0;
				tag_r[j] <= '0;
				st_r[j]  <= OK;
			end
			for (int j = 1; j < div_n_stages; j++) begin
				dvs_r[j] <= '0;
			end
		end else begin
			// First register takes the guard output directly
			rq_r[1]  <= {remd[0], req.dividend[w_shift-1:0], quot[0]};
			dvs_r[1] <= req.divisor;
			vld_r[1] <= req.valid;
			tag_r[1] <= req.tag;
			st_r[1]  <= req.status;

			for (int j = 2; j <= div_n_stages; j++) begin
				rq_r[j]  <= {remd[j-1], rq_r[j-1][w_shift-1:0], quot[j-1]};
				vld_r[j] <= vld_r[j-1];
				tag_r[j] <= tag_r[j-1];
				st_r[j]  <= st_r[j-1];
			end
			for (int j = 2; j < div_n_stages; j++) begin
				dvs_r[j] <= dvs_r[j-1];  // Last stage needs no divisor after it
			end
		end
	end

	// Failed requests return all-ones quotient and zero remainder
	assign out_valid     = vld_r[div_n_stages];
	assign out_tag       = tag_r[div_n_stages];
	assign out_status    = st_r[div_n_stages];
	assign out_quotient  = (st_r[div_n_stages] == OK) ?
	                       rq_r[div_n_stages][div_w_quotient-1:0] : '1;
	assign out_remainder = (st_r[div_n_stages] == OK) ?
	                       rq_r[div_n_stages][`DIV_W_DIVIDEND-1 -: `DIV_W_DIVISOR] : '0;

endmodule

/* div_unit.sv */
// Pipelined divider unit
// 44 / 12 bit unsigned, one result per clock

`timescale 1ns/100ps

module div_unit
	import div_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        in_valid,
	input  dividend_t   in_dividend,
	input  divisor_t    in_divisor,
	input  tag_t        in_tag,

	output logic        out_valid,
	output quotient_t   out_quotient,
	output divisor_t    out_remainder,
	output tag_t        out_tag,
	output div_status_t out_status
);

	div_req_if req_bus ();  // Guard to pipeline

	div_guard u_guard (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_dividend (in_dividend),
		.in_divisor  (in_divisor),
		.in_tag      (in_tag),
		.req         (req_bus)
	);

	// Eight register stages after the guard register
	div_pipe u_pipe (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req_bus),
		.out_valid     (out_valid),
		.out_quotient  (out_quotient),
		.out_remainder (out_remainder),
		.out_tag       (out_tag),
		.out_status    (out_status)
	);

endmodule

/* tb_clk_gen.sv */
// Testbench clock source

`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;  // 10 ns period

endmodule

/* tb_div_unit.sv */
// Divider unit testbench
// Random requests checked against a reference model

`timescale 1ns/100ps

`include "div_config.svh"

module tb_div_unit
	import div_pkg::*;
();

	localparam int latency     = 9;   // Falling edge of drive to falling edge of result
	localparam int rst_cycles  = 8;
	localparam int idle_cycles = 10;
	localparam int n_valid     = 40;
	localparam int n_dbz       = 12;
	localparam int n_ovf       = 12;
	localparam int n_stream    = 80;
	localparam int n_gapped    = 24;
	localparam int gap_cycles  = 24;  // Sum of i % 3 over the gapped requests
	localparam int n_tests     = 6;
	localparam int cycle_limit = rst_cycles + idle_cycles + n_valid + n_dbz + n_ovf +
	                             n_stream + n_gapped + gap_cycles +
	                             n_tests * (latency + 1) + latency + 50;

	typedef struct packed {
		tag_t        tag;
		div_status_t status;
		quotient_t   quotient;
		divisor_t    remainder;
		divisor_t    divisor;
		int          due;       // Cycle count at which the result must show
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	dividend_t   in_dividend;
	divisor_t    in_divisor;
	tag_t        in_tag;
	logic        out_valid;
	quotient_t   out_quotient;
	divisor_t    out_remainder;
	tag_t        out_tag;
	div_status_t out_status;

	integer  seed      = 98891;
	int      cycle_cnt = 0;
	int      err_cnt   = 0;
	int      pass_cnt  = 0;
	int      fail_cnt  = 0;
	tag_t    next_tag  = '0;
	expect_t exp_q[$];

	tb_clk_gen u_clk (
		.clk (clk)
	);

	div_unit UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_dividend   (in_dividend),
		.in_divisor    (in_divisor),
		.in_tag        (in_tag),
		.out_valid     (out_valid),
		.out_quotient  (out_quotient),
		.out_remainder (out_remainder),
		.out_tag       (out_tag),
		.out_status    (out_status)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout after %0d cycles: %0d results did not arrive",
			         cycle_cnt, exp_q.size());
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	function automatic dividend_t rand_dividend();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = rand32();
		lo = rand32();
		rand_dividend = {hi[`DIV_W_DIVIDEND-33:0], lo};
	endfunction

	function automatic divisor_t rand_divisor();
		logic [31:0] r;
		divisor_t    d;
		r = rand32();
		d = r[`DIV_W_DIVISOR-1:0];
		if (d == '0) begin
			d = divisor_t'(1);
		end
		rand_divisor = d;
	endfunction

	// Upper dividend bits kept below the divisor
	function automatic dividend_t valid_dividend(input divisor_t divisor);
		logic [31:0] top;
		logic [31:0] lo;
		top = rand32() % 32'(divisor);
		lo  = rand32();
		valid_dividend = {top[`DIV_W_DIVISOR-1:0], lo};
	endfunction

	// Upper dividend bits between the divisor and all ones
	function automatic dividend_t overflow_dividend(input divisor_t divisor);
		logic [31:0] top;
		logic [31:0] lo;
		top = 32'(divisor) + (rand32() % ((32'd1 << `DIV_W_DIVISOR) - 32'(divisor)));
		lo  = rand32();
		overflow_dividend = {top[`DIV_W_DIVISOR-1:0], lo};
	endfunction

	// Reference model with plain 64-bit division
	function automatic expect_t expected_result(input dividend_t dividend,
	                                             input divisor_t divisor, input tag_t tag);
		expect_t     e;
		logic [63:0] a64;
		logic [63:0] d64;
		logic [63:0] q64;
		logic [63:0] r64;
		e.tag     = tag;
		e.divisor = divisor;
		e.due     = 0;
		a64       = 64'(dividend);
		d64       = 64'(divisor);
		if (divisor == '0) begin
			e.status    = DIV_BY_ZERO;
			e.quotient  = '1;
			e.remainder = '0;
		end else begin
			q64 = a64 / d64;
			r64 = a64 % d64;
			if (q64 > 64'h0000_0000_FFFF_FFFF) begin
				e.status    = OVERFLOW;   // Quotient needs more than 32 bits
				e.quotient  = '1;
				e.remainder = '0;
			end else begin
				e.status    = OK;
				e.quotient  = q64[31:0];
				e.remainder = r64[`DIV_W_DIVISOR-1:0];
			end
		end
		expected_result = e;
	endfunction

	task automatic check_outputs();
		expect_t e;
		if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected result at %0t: out_valid high with no request pending",
				         $time);
				err_cnt++;
			end else begin
				e = exp_q.pop_front();
				if (cycle_cnt != e.due) begin
					$display("MISMATCH at %0t: tag %h arrived at cycle %0d, expected %0d",
					         $time, e.tag, cycle_cnt, e.due);
					err_cnt++;
				end
				if (out_tag !== e.tag) begin
					$display("MISMATCH at %0t: tag got %h expected %h",
					         $time, out_tag, e.tag);
					err_cnt++;
				end
				if (out_status !== e.status) begin
					$display("MISMATCH at %0t: tag %h status got %0d expected %0d",
					         $time, e.tag, out_status, e.status);
					err_cnt++;
				end
				if (out_quotient !== e.quotient) begin
					$display("MISMATCH at %0t: tag %h quotient got %h expected %h",
					         $time, e.tag, out_quotient, e.quotient);
					err_cnt++;
				end
				if (out_remainder !== e.remainder) begin
					$display("MISMATCH at %0t: tag %h remainder got %h expected %h",
					         $time, e.tag, out_remainder, e.remainder);
					err_cnt++;
				end
				if (e.status == OK && out_remainder >= e.divisor) begin
					$display("MISMATCH at %0t: tag %h remainder %h not below divisor %h",
					         $time, e.tag, out_remainder, e.divisor);
					err_cnt++;
				end
			end
		end else if (out_valid !== 1'b0) begin
			$display("Unknown out_valid at %0t", $time);
			err_cnt++;
		end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
			e = exp_q.pop_front();
			$display("Missing result at %0t: tag %h was due at cycle %0d",
			         $time, e.tag, e.due);
			err_cnt++;
		end
	endtask

	// Outputs are sampled before new inputs go out on the same falling edge
	task automatic next_cycle();
		@(negedge clk);
		check_outputs();
	endtask

	task automatic send_request(input dividend_t dividend, input divisor_t divisor);
		expect_t e;
		next_cycle();
		in_valid    = 1'b1;
		in_dividend = dividend;
		in_divisor  = divisor;
		in_tag      = next_tag;
		e           = expected_result(dividend, divisor, next_tag);
		e.due       = cycle_cnt + latency;
		exp_q.push_back(e);
		next_tag    = next_tag + 1'b1;
	endtask

	task automatic idle_cycle();
		next_cycle();
		in_valid    = 1'b0;
		in_dividend = rand_dividend();  // Data with no strobe must be ignored
		in_divisor  = rand_divisor();
		in_tag      = next_tag;
	endtask

	task automatic drain();
		do begin
			idle_cycle();
		end while (exp_q.size() != 0);
	endtask

	task automatic send_mixed();
		logic [31:0] r;
		divisor_t    dvs;
		r   = rand32() % 32'd4;
		dvs = rand_divisor();
		case (r[1:0])
			2'd2:    send_request(rand_dividend(), '0);
			2'd3:    send_request(overflow_dividend(dvs), dvs);
			default: send_request(valid_dividend(dvs), dvs);
		endcase
	endtask

	task automatic finish_test(input string name, input int err_mark);
		if (err_cnt == err_mark) begin
			pass_cnt++;
			$display("Test %s passed", name);
		end else begin
			fail_cnt++;
			$display("Test %s failed with %0d errors", name, err_cnt - err_mark);
		end
	endtask

	initial begin
		int       err_mark;
		divisor_t dvs;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_dividend = '0;
		in_divisor  = '0;
		in_tag      = '0;

		err_mark = err_cnt;
		repeat (rst_cycles) next_cycle();
		rst_n = 1'b1;
		repeat (idle_cycles) idle_cycle();  // No result may appear before a request
		finish_test("reset_idle", err_mark);

		err_mark = err_cnt;
		for (int i = 0; i < n_valid; i++) begin
			dvs = rand_divisor();
			send_request(valid_dividend(dvs), dvs);
		end
		drain();
		finish_test("valid_random", err_mark);

		err_mark = err_cnt;
		for (int i = 0; i < n_dbz; i++) begin
			send_request(rand_dividend(), '0);
		end
		drain();
		finish_test("div_by_zero", err_mark);

		err_mark = err_cnt;
		for (int i = 0; i < n_ovf; i++) begin
			dvs = rand_divisor();
			send_request(overflow_dividend(dvs), dvs);
		end
		drain();
		finish_test("overflow", err_mark);

		err_mark = err_cnt;
		for (int i = 0; i < n_stream; i++) begin
			send_mixed();
		end
		drain();
		finish_test("back_to_back", err_mark);

		err_mark = err_cnt;
		for (int i = 0; i < n_gapped; i++) begin
			send_mixed();
			repeat (i % 3) idle_cycle();
		end
		drain();
		finish_test("gapped_stream", err_mark);

		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* div_unit.f */
+incdir+.
div_pkg.sv
div_req_if.sv
div_digit.sv
div_guard.sv
div_pipe.sv
div_unit.sv
tb_clk_gen.sv
tb_div_unit.sv

/* Makefile */
# Verilator build for the pipelined divider unit

VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = tb_div_unit
FILELIST  = div_unit.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
